// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module gameTb \
		-Mdir obj_dir -o gameSim

run: compile
	./obj_dir/gameSim | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    input  logic restart,
    output logic clk,
    output logic rstReg
);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Two reset edges at start-up and again after each restart request
    initial begin
        rstReg = 1'b1;
        forever begin
            repeat (2) @(posedge clk);
            #2;
            rstReg = 1'b0;
            @(posedge restart);
            rstReg = 1'b1;
        end
    end

endmodule

// File: bench/gameChecker.sv
`timescale 1ns/1ps
`include "tetris_settings.svh"

module gameChecker (
    input  logic                   clk,
    input  logic                   rstReg,
    input  logic                   fail,
    input  logic                   shiftEn,
    input  logic [4:0]             shiftLimit,
    input  logic                   cmdReady,
    input  logic [`BOARD_ROWS-1:0] full,
    input  tetrisPkg::score_t      score
);

    // Read by the testbench at the end of the run
    int assertFails = 0;

    failSticky: assert property (@(posedge clk) disable iff (rstReg) $past(fail) |-> fail)
        else begin
            assertFails++;
            $error("fail fell without a reset");
        end

    scoreRising: assert property (@(posedge clk) disable iff (rstReg) score >= $past(score))
        else begin
            assertFails++;
            $error("score decreased");
        end

    // Cleared row is full and no full row lies below it
    shiftNeedsFull: assert property (@(posedge clk) disable iff (rstReg)
        shiftEn |-> (full >> shiftLimit) == `BOARD_ROWS'(1))
        else begin
            assertFails++;
            $error("shiftEn without the lowest full row selected");
        end

    shiftBlocksCmd: assert property (@(posedge clk) disable iff (rstReg) shiftEn |-> !cmdReady)
        else begin
            assertFails++;
            $error("cmdReady high during a row clear");
        end

endmodule

// File: bench/gameTb.sv
`timescale 1ns/1ps
`include "tetris_settings.svh"

module gameTb;
    import tetrisPkg::*;

    localparam int NUM_CMDS = 3000;
    localparam int WATCHDOG_NS = NUM_CMDS * 30 * 40;
    localparam int WAIT_LIMIT = 60;
    localparam int CMDS_AFTER_FAIL = 25;

    logic                                clk;
    logic                                rstReg;
    logic                                restart;
    gameCmd_t                            cmd;
    logic                                cmdValid;
    logic                                cmdReady;
    logic [`BOARD_ROWS*`BOARD_COLS-1:0]  objects;
    score_t                              score;
    logic                                fail;

    integer seed;
    int     checks;
    int     valueErrors;
    int     otherErrors;
    int     failCmds;

    // Reference model state
    rowBits_t board [`BOARD_ROWS];
    bit       pActive;
    int       pKind;
    int       pRot;
    int       pRow;
    int       pCol;
    int       modelScore;
    bit       modelFail;

    clockGen clkGen (
        .restart (restart),
        .clk     (clk),
        .rstReg  (rstReg)
    );

    gameTop dut_i (
        .clk      (clk),
        .rstReg   (rstReg),
        .cmd      (cmd),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .objects  (objects),
        .score    (score),
        .fail     (fail)
    );

    bind gameTop gameChecker chk (
        .clk        (clk),
        .rstReg     (rstReg),
        .fail       (fail),
        .shiftEn    (shiftEn),
        .shiftLimit (shiftLimit),
        .cmdReady   (cmdReady),
        .full       (full),
        .score      (score)
    );

    // ######################################################################
    // Reference model
    // ######################################################################

    // Offsets as row, col pairs; index is kind*4 + rotation
    function automatic void shapeOf(input int kind, input int rot,
                                    output int dr [4], output int dc [4]);
        int t [8];
        case (kind * 4 + rot)
            0, 2:       t = '{0, -2, 0, -1, 0, 0, 0, 1};
            1, 3:       t = '{-2, 0, -1, 0, 0, 0, 1, 0};
            4, 5, 6, 7: t = '{0, 0, 0, 1, 1, 0, 1, 1};
            8:          t = '{0, -1, 0, 0, 0, 1, -1, 0};
            9:          t = '{-1, 0, 0, 0, 1, 0, 0, 1};
            10:         t = '{0, -1, 0, 0, 0, 1, 1, 0};
            11:         t = '{-1, 0, 0, 0, 1, 0, 0, -1};
            12:         t = '{0, -1, 0, 0, 0, 1, -1, 1};
            13:         t = '{-1, 0, 0, 0, 1, 0, 1, 1};
            14:         t = '{0, -1, 0, 0, 0, 1, 1, -1};
            15:         t = '{-1, 0, 0, 0, 1, 0, -1, -1};
            16:         t = '{0, -1, 0, 0, -1, 0, -1, 1};
            17:         t = '{0, 0, 0, -1, -1, -1, 1, 0};
            18:         t = '{0, 0, 0, 1, -1, -1, -1, 0};
            default:    t = '{0, 0, 0, -1, -1, 0, 1, -1};
        endcase
        for (int k = 0; k < 4; k++) begin
            dr[k] = t[2*k];
            dc[k] = t[2*k+1];
        end
    endfunction

    function automatic bit fits(input int kind, input int rot, input int row, input int col);
        int dr [4];
        int dc [4];
        int r;
        int c;
        bit ok;
        shapeOf(kind, rot, dr, dc);
        ok = 1'b1;
        for (int k = 0; k < 4; k++) begin
            r = row + dr[k];
            c = col + dc[k];
            if (r < 0 || r >= `BOARD_ROWS || c < 0 || c >= `BOARD_COLS) begin
                ok = 1'b0;
            end else if (board[r][c]) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic logic [`BOARD_ROWS*`BOARD_COLS-1:0] expectedObjects();
        logic [`BOARD_ROWS*`BOARD_COLS-1:0] o;
        int dr [4];
        int dc [4];
        o = '0;
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            o[r*`BOARD_COLS +: `BOARD_COLS] = board[r];
        end
        if (pActive) begin
            shapeOf(pKind, pRot, dr, dc);
            for (int k = 0; k < 4; k++) begin
                o[(pRow + dr[k]) * `BOARD_COLS + pCol + dc[k]] = 1'b1;
            end
        end
        return o;
    endfunction

    task automatic resetModel();
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            board[r] = '0;
        end
        pActive = 1'b0;
        modelScore = 0;
        modelFail = 1'b0;
        failCmds = 0;
    endtask

    // Settle the piece, then remove full rows from the bottom up
    task automatic lockPiece();
        int dr [4];
        int dc [4];
        int r;
        shapeOf(pKind, pRot, dr, dc);
        for (int k = 0; k < 4; k++) begin
            board[pRow + dr[k]][pCol + dc[k]] = 1'b1;
        end
        pActive = 1'b0;
        modelScore += `LAND_POINTS;
        r = `BOARD_ROWS - 1;
        while (r >= 0) begin
            if (&board[r]) begin
                for (int k = r; k > 0; k--) begin
                    board[k] = board[k-1];
                end
                board[0] = '0;
                modelScore += `ROW_POINTS;
            end else begin
                r--;
            end
        end
    endtask

    task automatic modelApply(input int op, input int pay);
        int step;
        if (!modelFail) begin
            case (op)
                0: begin
                    if (!pActive && pay <= 4) begin
                        if (fits(pay, 0, `SPAWN_ROW, `SPAWN_COL)) begin
                            pActive = 1'b1;
                            pKind = pay;
                            pRot = 0;
                            pRow = `SPAWN_ROW;
                            pCol = `SPAWN_COL;
                        end else begin
                            modelFail = 1'b1;
                        end
                    end
                end
                1: begin
                    step = (pay == 0) ? -1 : 1;
                    if (pActive && fits(pKind, pRot, pRow, pCol + step)) begin
                        pCol += step;
                    end
                end
                2: begin
                    if (pActive && fits(pKind, (pRot + 1) % 4, pRow, pCol)) begin
                        pRot = (pRot + 1) % 4;
                    end
                end
                default: begin
                    if (pActive) begin
                        if (fits(pKind, pRot, pRow + 1, pCol)) begin
                            pRow++;
                        end else begin
                            lockPiece();
                        end
                    end
                end
            endcase
        end
    endtask

    // ######################################################################
    // Stimulus and checks
    // ######################################################################

    // Mostly drops, so the stack grows and rows fill
    task automatic pickCmd(output int op, output int pay);
        int roll;
        roll = {$random(seed)} % 100;
        if ((!pActive && roll < 85) || roll < 4) begin
            op = 0;
            pay = {$random(seed)} % 8;
            if (pay > 4 && ({$random(seed)} % 2 == 1)) begin
                pay = pay - 5;
            end
        end else if (roll < 30) begin
            op = 1;
            pay = {$random(seed)} % 2;
        end else if (roll < 42) begin
            op = 2;
            pay = {$random(seed)} % 8;
        end else begin
            op = 3;
            pay = {$random(seed)} % 8;
        end
    endtask

    task automatic sendCmd(input int op, input int pay);
        int waited;
        bit seen;
        @(posedge clk);
        #2;
        cmd = gameCmd_t'({2'(op), 3'(pay)});
        cmdValid = 1'b1;
        seen = 1'b0;
        waited = 0;
        while (!seen && waited < WAIT_LIMIT) begin
            @(negedge clk);
            seen = cmdReady;
            @(posedge clk);
            waited++;
        end
        #2;
        cmdValid = 1'b0;
        if (!seen) begin
            $display("Command op %0d was never accepted at %0t", op, $time);
            otherErrors++;
        end
    endtask

    task automatic waitReady();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!cmdReady && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!cmdReady) begin
            $display("cmdReady stayed low after a command at %0t", $time);
            otherErrors++;
        end
    endtask

    task automatic checkValues();
        logic [`BOARD_ROWS*`BOARD_COLS-1:0] expObj;
        expObj = expectedObjects();
        checks++;
        if (objects !== expObj) begin
            $display("ERR t=%0t objects expected %h got %h", $time, expObj, objects);
            valueErrors++;
        end
        if (score !== score_t'(modelScore)) begin
            $display("ERR t=%0t score expected %0d got %0d", $time, modelScore, score);
            valueErrors++;
        end
        if (fail !== modelFail) begin
            $display("ERR t=%0t fail expected %0b got %0b", $time, modelFail, fail);
            valueErrors++;
        end
    endtask

    task automatic checkIdle();
        checkValues();
        if (cmdReady !== 1'b1) begin
            $display("ERR t=%0t cmdReady expected 1 got %b", $time, cmdReady);
            valueErrors++;
        end
    endtask

    task automatic restartGame();
        @(posedge clk);
        #2;
        restart = 1'b1;
        #1;
        restart = 1'b0;
        wait (rstReg === 1'b0);
        resetModel();
        @(negedge clk);
        checkIdle();
    endtask

    initial begin
        int op;
        int pay;
        seed = 47;
        checks = 0;
        valueErrors = 0;
        otherErrors = 0;
        restart = 1'b0;
        cmd = '0;
        cmdValid = 1'b0;
        resetModel();
        wait (rstReg === 1'b0);
        @(negedge clk);
        checkIdle();
        for (int n = 0; n < NUM_CMDS; n++) begin
            pickCmd(op, pay);
            modelApply(op, pay);
            sendCmd(op, pay);
            waitReady();
            checkValues();
            // A lost game runs on a while, then a new one starts
            if (modelFail) begin
                failCmds++;
                if (failCmds > CMDS_AFTER_FAIL) begin
                    restartGame();
                end
            end
        end
        $display("%0d checks, %0d value errors, %0d other errors, %0d assertion failures",
                 checks, valueErrors, otherErrors, dut_i.chk.assertFails);
        if (valueErrors + otherErrors + dut_i.chk.assertFails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all commands were sent");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: list.f
+incdir+rtl
rtl/tetrisPkg.sv
rtl/pieceControl.sv
rtl/boardRow.sv
rtl/rowCollector.sv
rtl/gameTop.sv
bench/clockGen.sv
bench/gameChecker.sv
bench/gameTb.sv

// File: rtl/boardRow.sv
`timescale 1ns/1ps

module boardRow (
    input  logic                clk,
    input  logic                rstReg,
    input  tetrisPkg::rowBits_t lockBits,
    input  tetrisPkg::rowBits_t aboveBits,
    input  logic                shiftIn,
    output tetrisPkg::rowBits_t bits,
    output logic                full
);

    // Shift wins over lock, the two never meet in one cycle
    always_ff @(posedge clk) begin
        if (rstReg) begin
            bits <= '0;
        end else if (shiftIn) begin
            bits <= aboveBits;
        end else begin
            bits <= bits | lockBits;
        end
    end

    assign full = &bits;

endmodule

// File: rtl/gameTop.sv
`timescale 1ns/1ps
`include "tetris_settings.svh"

module gameTop (
    input  logic                                clk,
    input  logic                                rstReg,
    input  tetrisPkg::gameCmd_t                 cmd,
    input  logic                                cmdValid,
    output logic                                cmdReady,
    output logic [`BOARD_ROWS*`BOARD_COLS-1:0]  objects,
    output tetrisPkg::score_t                   score,
    output logic                                fail
);
    import tetrisPkg::*;

    rowBits_t                settled [`BOARD_ROWS];
    rowBits_t                lockMask [`BOARD_ROWS];
    rowBits_t                pieceMask [`BOARD_ROWS];
    rowBits_t                aboveBits [`BOARD_ROWS];
    logic [`BOARD_ROWS-1:0]  full;
    logic                    shiftEn;
    logic [4:0]              shiftLimit;
    logic                    clearBusy;
    logic                    landed;

    pieceControl pieceCtrl (
        .clk       (clk),
        .rstReg    (rstReg),
        .cmd       (cmd),
        .cmdValid  (cmdValid),
        .rows      (settled),
        .clearBusy (clearBusy),
        .cmdReady  (cmdReady),
        .lockMask  (lockMask),
        .pieceMask (pieceMask),
        .landed    (landed),
        .fail      (fail)
    );

    // ######################################################################
    // Board rows, row 0 at the top
    // ######################################################################
    for (genvar r = 0; r < `BOARD_ROWS; r++) begin : gRow
        // Rows from the top down to the cleared one move down by one
        wire shiftIn = shiftEn && (5'(r) <= shiftLimit);

        if (r == 0) begin : gTop
            assign aboveBits[r] = '0;
        end else begin : gBelow
            assign aboveBits[r] = settled[r-1];
        end

        boardRow row (
            .clk       (clk),
            .rstReg    (rstReg),
            .lockBits  (lockMask[r]),
            .aboveBits (aboveBits[r]),
            .shiftIn   (shiftIn),
            .bits      (settled[r]),
            .full      (full[r])
        );
    end

    rowCollector collector (
        .clk        (clk),
        .rstReg     (rstReg),
        .full       (full),
        .rows       (settled),
        .pieceMask  (pieceMask),
        .landed     (landed),
        .shiftEn    (shiftEn),
        .shiftLimit (shiftLimit),
        .clearBusy  (clearBusy),
        .score      (score),
        .objects    (objects)
    );

endmodule

// File: rtl/pieceControl.sv
`timescale 1ns/1ps
`include "tetris_settings.svh"

module pieceControl (
    input  logic                clk,
    input  logic                rstReg,
    input  tetrisPkg::gameCmd_t cmd,
    input  logic                cmdValid,
    input  tetrisPkg::rowBits_t rows [`BOARD_ROWS],
    input  logic                clearBusy,
    output logic                cmdReady,
    output tetrisPkg::rowBits_t lockMask [`BOARD_ROWS],
    output tetrisPkg::rowBits_t pieceMask [`BOARD_ROWS],
    output logic                landed,
    output logic                fail
);
    import tetrisPkg::*;

    pieceState_t                  piece;
    pieceState_t                  cand;
    rowBits_t [`BOARD_ROWS-1:0]   candMask;
    rowBits_t [`BOARD_ROWS-1:0]   curMask;
    rowBits_t [`BOARD_ROWS-1:0]   lockReg;
    logic                         candInBounds;
    logic                         candHit;
    logic                         candFree;
    logic                         kindValid;
    logic                         accept;

    // ######################################################################
    // Shape table
    // ######################################################################

    // One cell packed as {rowOffset, colOffset}, both 3-bit two's complement
    function automatic logic [5:0] cellAt(input int dr, input int dc);
        cellAt = {3'(dr), 3'(dc)};
    endfunction

    function automatic logic [23:0] shapeCells(input pieceKind_t kind, input logic [1:0] rot);
        logic [23:0] c;
        c = '0;
        case (kind)
            kindI: begin
                if (rot[0]) begin
                    c = {cellAt(-2, 0), cellAt(-1, 0), cellAt(0, 0), cellAt(1, 0)};
                end else begin
                    c = {cellAt(0, -2), cellAt(0, -1), cellAt(0, 0), cellAt(0, 1)};
                end
            end
            kindO: c = {cellAt(0, 0), cellAt(0, 1), cellAt(1, 0), cellAt(1, 1)};
            kindT: begin
                case (rot)
                    2'd0: c = {cellAt(0, -1), cellAt(0, 0), cellAt(0, 1), cellAt(-1, 0)};
                    2'd1: c = {cellAt(-1, 0), cellAt(0, 0), cellAt(1, 0), cellAt(0, 1)};
                    2'd2: c = {cellAt(0, -1), cellAt(0, 0), cellAt(0, 1), cellAt(1, 0)};
                    default: c = {cellAt(-1, 0), cellAt(0, 0), cellAt(1, 0), cellAt(0, -1)};
                endcase
            end
            kindL: begin
                case (rot)
                    2'd0: c = {cellAt(0, -1), cellAt(0, 0), cellAt(0, 1), cellAt(-1, 1)};
                    2'd1: c = {cellAt(-1, 0), cellAt(0, 0), cellAt(1, 0), cellAt(1, 1)};
                    2'd2: c = {cellAt(0, -1), cellAt(0, 0), cellAt(0, 1), cellAt(1, -1)};
                    default: c = {cellAt(-1, 0), cellAt(0, 0), cellAt(1, 0), cellAt(-1, -1)};
                endcase
            end
            kindS: begin
                case (rot)
                    2'd0: c = {cellAt(0, -1), cellAt(0, 0), cellAt(-1, 0), cellAt(-1, 1)};
                    2'd1: c = {cellAt(0, 0), cellAt(0, -1), cellAt(-1, -1), cellAt(1, 0)};
                    2'd2: c = {cellAt(0, 0), cellAt(0, 1), cellAt(-1, -1), cellAt(-1, 0)};
                    default: c = {cellAt(0, 0), cellAt(0, -1), cellAt(-1, 0), cellAt(1, -1)};
                endcase
            end
            default: c = '0;
        endcase
        return c;
    endfunction

    // Returns 1 when all four cells land on the board
    function automatic logic placePiece(input pieceState_t p,
                                        output rowBits_t [`BOARD_ROWS-1:0] mask);
        logic [23:0]       cells;
        logic signed [6:0] r;
        logic signed [6:0] c;
        logic              ok;
        cells = shapeCells(p.kind, p.rot);
        mask = '0;
        ok = 1'b1;
        for (int k = 0; k < 4; k++) begin
            r = $signed({2'b00, p.row}) + $signed(cells[k*6+3 +: 3]);
            c = $signed({3'b000, p.col}) + $signed(cells[k*6 +: 3]);
            if (r < 0 || r >= `BOARD_ROWS || c < 0 || c >= `BOARD_COLS) begin
                ok = 1'b0;
            end else begin
                mask[r[4:0]][c[3:0]] = 1'b1;
            end
        end
        return ok;
    endfunction

    // ######################################################################
    // Candidate position
    // ######################################################################
    always_comb begin
        cand = piece;
        case (cmd.op)
            opSpawn: begin
                cand.active = 1'b1;
                cand.kind = cmd.payload.kind;
                cand.rot = 2'd0;
                cand.row = 5'(`SPAWN_ROW);
                cand.col = 4'(`SPAWN_COL);
            end
            opShift: begin
                case (cmd.payload.dir)
                    // Wraps past 0 to 15, which fails the bounds check
                    dirLeft: cand.col = piece.col - 4'd1;
                    dirRight: cand.col = piece.col + 4'd1;
                    default: cand.col = piece.col;
                endcase
            end
            opRotate: cand.rot = piece.rot + 2'd1;
            default: cand.row = piece.row + 5'd1;
        endcase
    end

    always_comb begin
        candInBounds = placePiece(cand, candMask);
        void'(placePiece(piece, curMask));
        candHit = 1'b0;
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            candHit = candHit | (|(candMask[r] & rows[r]));
        end
        candFree = candInBounds && !candHit;
    end

    assign kindValid = (cmd.payload.kind <= kindS);
    assign cmdReady = !landed && !clearBusy;
    assign accept = cmdValid && cmdReady;

    // ######################################################################
    // Piece state
    // ######################################################################
    always_ff @(posedge clk) begin
        if (rstReg) begin
            piece <= '0;
            fail <= 1'b0;
            landed <= 1'b0;
            lockReg <= '0;
        end else begin
            landed <= 1'b0;
            lockReg <= '0;
            if (accept && !fail) begin
                case (cmd.op)
                    opSpawn: begin
                        if (!piece.active && kindValid) begin
                            if (candFree) begin
                                piece <= cand;
                            end else begin
                                fail <= 1'b1;
                            end
                        end
                    end
                    opDrop: begin
                        if (piece.active) begin
                            if (candFree) begin
                                piece <= cand;
                            end else begin
                                // Settle in place
                                lockReg <= curMask;
                                landed <= 1'b1;
                                piece.active <= 1'b0;
                            end
                        end
                    end
                    default: begin
                        if (piece.active && candFree) begin
                            piece <= cand;
                        end
                    end
                endcase
            end
        end
    end

    always_comb begin
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            lockMask[r] = lockReg[r];
            pieceMask[r] = piece.active ? curMask[r] : '0;
        end
    end

endmodule

// File: rtl/rowCollector.sv
`timescale 1ns/1ps
`include "tetris_settings.svh"

module rowCollector (
    input  logic                                    clk,
    input  logic                                    rstReg,
    input  logic [`BOARD_ROWS-1:0]                  full,
    input  tetrisPkg::rowBits_t                     rows [`BOARD_ROWS],
    input  tetrisPkg::rowBits_t                     pieceMask [`BOARD_ROWS],
    input  logic                                    landed,
    output logic                                    shiftEn,
    output logic [4:0]                              shiftLimit,
    output logic                                    clearBusy,
    output tetrisPkg::score_t                       score,
    output logic [`BOARD_ROWS*`BOARD_COLS-1:0]      objects
);
    import tetrisPkg::*;

    logic [4:0] lowestFull;
    score_t     gain;

    // ######################################################################
    // Row clearing
    // ######################################################################

    // Highest index is the lowest row on screen
    always_comb begin
        lowestFull = '0;
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            if (full[r]) begin
                lowestFull = 5'(r);
            end
        end
    end

    assign shiftEn = |full;
    assign shiftLimit = lowestFull;
    assign clearBusy = |full;

    // ######################################################################
    // Score
    // ######################################################################
    always_comb begin
        gain = '0;
        if (landed) begin
            gain = gain + score_t'(`LAND_POINTS);
        end
        if (shiftEn) begin
            gain = gain + score_t'(`ROW_POINTS);
        end
    end

    always_ff @(posedge clk) begin
        if (rstReg) begin
            score <= '0;
        end else begin
            score <= score + gain;
        end
    end

    // Settled cells plus the falling piece
    always_comb begin
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            objects[r*`BOARD_COLS +: `BOARD_COLS] = rows[r] | pieceMask[r];
        end
    end

endmodule

// File: rtl/tetrisPkg.sv
`include "tetris_settings.svh"

package tetrisPkg;

    // Bit c is column c, column 0 on the left
    typedef logic [`BOARD_COLS-1:0] rowBits_t;

    // Values 5 to 7 are not a piece
    typedef enum logic [2:0] {
        kindI = 3'd0,
        kindO = 3'd1,
        kindT = 3'd2,
        kindL = 3'd3,
        kindS = 3'd4
    } pieceKind_t;

    // Same width as pieceKind_t so both fit the payload field
    typedef enum logic [2:0] {
        dirLeft  = 3'd0,
        dirRight = 3'd1
    } moveDir_t;

    // Spawn reads kind, shift reads dir
    typedef union packed {
        pieceKind_t kind;
        moveDir_t   dir;
    } cmdPayload_t;

    typedef enum logic [1:0] {
        opSpawn  = 2'd0,
        opShift  = 2'd1,
        opRotate = 2'd2,
        opDrop   = 2'd3
    } cmdOp_t;

    typedef struct packed {
        cmdOp_t      op;
        cmdPayload_t payload;
    } gameCmd_t;

    typedef struct packed {
        logic       active;
        pieceKind_t kind;
        logic [1:0] rot;
        logic [4:0] row;
        logic [3:0] col;
    } pieceState_t;

    typedef logic [15:0] score_t;

endpackage

// File: rtl/tetris_settings.svh
`ifndef TETRIS_SETTINGS_SVH
`define TETRIS_SETTINGS_SVH

// ######################################################################
// Board geometry
// ######################################################################
`define BOARD_ROWS 20
`define BOARD_COLS 10

// Center cell of a freshly spawned piece
`define SPAWN_ROW 2
`define SPAWN_COL 5

// ######################################################################
// Scoring
// ######################################################################
`define LAND_POINTS 1
`define ROW_POINTS 10

`endif
